/* source/powerCtrlPkg.sv */
// Power controller shared package with domain count, register map, widths and sequencer states
package powerCtrlPkg;

  // ----------------------------------------
  // Sizes and timing
  // ----------------------------------------

  // Number of switchable power domains
  localparam int NumDomains = 2;

  // Cycles spent in PwrOn2 before restore
  localparam int SettleCycles = 28;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // Register address
  typedef logic [3:0] regAddrT;

  // Register read and write data
  typedef logic [7:0] regDataT;

  // One bit per power domain
  typedef logic [NumDomains-1:0] domainMaskT;

  // Settle counter, wide enough for SettleCycles
  typedef logic [4:0] settleCntT;

  // ----------------------------------------
  // Register map
  // ----------------------------------------

  // Request register, read/write
  localparam regAddrT AddrL1Req = 4'd0;

  // Status register, read only
  localparam regAddrT AddrStatus = 4'd1;

  // Sequencer states, shutoff path then wake path
  typedef enum logic [3:0] {
    Init        = 4'd0,
    ClkOff      = 4'd1,
    Wait1       = 4'd2,
    Isolate     = 4'd3,
    SaveEdge    = 4'd4,
    PrePwrOff   = 4'd5,
    PwrOff      = 4'd6,
    PwrOn1      = 4'd7,
    PwrOn2      = 4'd8,
    RestoreEdge = 4'd9,
    Wait2       = 4'd10,
    DeIsolate   = 4'd11,
    ClkOn       = 4'd12,
    Wait3       = 4'd13,
    RstClr      = 4'd14
  } pwrStateT;

endpackage

/* source/pwrSeqFsm.sv */
// Power shutoff and wake sequencer for a single switchable domain
`timescale 1ns/1ps

module pwrSeqFsm (
  input  logic pclk10,
  input  logic nprst10,
  input  logic l1Req,
  output logic setStatus,
  output logic clrStatus,
  output logic gateClk,
  output logic isolate,
  output logic saveEdge,
  output logic restoreEdge,
  output logic pwr1On,
  output logic pwr2On,
  output logic rstnNonSrpg
);

  import powerCtrlPkg::*;

  // State register and next state
  pwrStateT state;
  pwrStateT nextState;

  // Cycles spent in PwrOn2
  settleCntT settleCnt;

  // Settle time reached, leave PwrOn2 at the next edge
  logic settleDone;

  // Decoded output values for the next state
  logic gateClkNext;
  logic isolateNext;
  logic saveEdgeNext;
  logic restoreEdgeNext;
  logic pwr1OnNext;
  logic pwr2OnNext;
  logic rstnNext;

  // Registered non-retention reset, before the chip reset is merged in
  logic rstnReg;

  // ----------------------------------------
  // Next state decode
  // ----------------------------------------

  // Count starts at zero on entry to PwrOn2
  assign settleDone = (settleCnt == settleCntT'(SettleCycles - 1));

  always_comb
  begin
    nextState = state;
    case (state)
      // Idle with power on until software asks for shutoff
      Init:
        if (l1Req)
          nextState = ClkOff;
      ClkOff:
        nextState = Wait1;
      // Let the clock gate settle
      Wait1:
        nextState = Isolate;
      Isolate:
        nextState = SaveEdge;
      SaveEdge:
        nextState = PrePwrOff;
      PrePwrOff:
        nextState = PwrOff;
      // Domain is off, wait for the request to drop
      PwrOff:
        if (!l1Req)
          nextState = PwrOn1;
      PwrOn1:
        nextState = PwrOn2;
      // Hold here while the supply settles
      PwrOn2:
        if (settleDone)
          nextState = RestoreEdge;
      RestoreEdge:
        nextState = Wait2;
      Wait2:
        nextState = DeIsolate;
      DeIsolate:
        nextState = ClkOn;
      // Wait for the clock to come back
      ClkOn:
        nextState = Wait3;
      Wait3:
        nextState = RstClr;
      RstClr:
        nextState = Init;
      default:
        nextState = Init;
    endcase
  end

  // ----------------------------------------
  // Output decode from next state
  // ----------------------------------------

  always_comb
  begin
    // Values for a powered, running domain
    gateClkNext     = 1'b1;
    isolateNext     = 1'b0;
    saveEdgeNext    = 1'b0;
    restoreEdgeNext = 1'b0;
    pwr1OnNext      = 1'b1;
    pwr2OnNext      = 1'b1;
    rstnNext        = 1'b0;

    // Clock runs only outside the gated window
    if (nextState inside {Init, ClkOn, Wait3, RstClr})
      gateClkNext = 1'b0;

    // Isolation spans the whole unpowered stretch
    if (nextState inside {Isolate, SaveEdge, PrePwrOff, PwrOff, PwrOn1, PwrOn2, RestoreEdge,
                          Wait2})
      isolateNext = 1'b1;

    // One cycle save and restore strobes
    if (nextState == SaveEdge)
      saveEdgeNext = 1'b1;
    if (nextState == RestoreEdge)
      restoreEdgeNext = 1'b1;

    // Switch 2 follows switch 1 by one cycle on wake
    if (nextState == PwrOff)
      pwr1OnNext = 1'b0;
    if (nextState inside {PwrOff, PwrOn1})
      pwr2OnNext = 1'b0;

    // Non-retention flops released before shutoff and again at RstClr
    if (nextState inside {Init, ClkOff, Wait1, Isolate, SaveEdge, PrePwrOff, RstClr})
      rstnNext = 1'b1;
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge pclk10 or negedge nprst10)
  begin
    if (!nprst10)
    begin
      state <= Init;
    end
    else
    begin
      state <= nextState;
    end
  end

  // Cleared in every state other than PwrOn2
  always_ff @(posedge pclk10 or negedge nprst10)
  begin
    if (!nprst10)
    begin
      settleCnt <= '0;
    end
    else if (state == PwrOn2)
    begin
      settleCnt <= settleCnt + 1'b1;
    end
    else
    begin
      settleCnt <= '0;
    end
  end

  // Control outputs change at the edge where their state is entered
  always_ff @(posedge pclk10 or negedge nprst10)
  begin
    if (!nprst10)
    begin
      gateClk     <= 1'b0;
      isolate     <= 1'b0;
      saveEdge    <= 1'b0;
      restoreEdge <= 1'b0;
      pwr1On      <= 1'b1;
      pwr2On      <= 1'b1;
      rstnReg     <= 1'b0;
    end
    else
    begin
      gateClk     <= gateClkNext;
      isolate     <= isolateNext;
      saveEdge    <= saveEdgeNext;
      restoreEdge <= restoreEdgeNext;
      pwr1On      <= pwr1OnNext;
      pwr2On      <= pwr2OnNext;
      rstnReg     <= rstnNext;
    end
  end

  // Chip reset also holds the non-retention flops in reset
  assign rstnNonSrpg = rstnReg & nprst10;

  // Status set as shutoff begins, cleared as wake ends
  assign setStatus = (nextState == ClkOff);
  assign clrStatus = (state == RstClr);

endmodule

/* source/pwrCtrlRegs.sv */
// Request and status register block with strobe writes and combinational read
`timescale 1ns/1ps

module pwrCtrlRegs (
  input  logic                    pclk10,
  input  logic                    nprst10,
  input  logic                    wrEn,
  input  powerCtrlPkg::regAddrT   addr,
  input  powerCtrlPkg::regDataT   wrData,
  output powerCtrlPkg::regDataT   rdData,
  input  powerCtrlPkg::domainMaskT setStatus,
  input  powerCtrlPkg::domainMaskT clrStatus,
  output powerCtrlPkg::domainMaskT l1Req
);

  import powerCtrlPkg::*;

  // Shutoff request, one bit per domain
  domainMaskT reqReg;

  // Domain is shut off or on its way down
  domainMaskT statusReg;

  // Write strobe aimed at the request register
  logic reqWr;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------

  // Only the request register is writable
  assign reqWr = wrEn && (addr == AddrL1Req);

  // Upper data bits beyond the domain count are dropped
  always_ff @(posedge pclk10 or negedge nprst10)
  begin
    if (!nprst10)
    begin
      reqReg <= '0;
    end
    else if (reqWr)
    begin
      reqReg <= wrData[NumDomains-1:0];
    end
  end

  assign l1Req = reqReg;

  // ----------------------------------------
  // Status bits
  // ----------------------------------------

  // Each sequencer owns its own bit
  always_ff @(posedge pclk10 or negedge nprst10)
  begin
    if (!nprst10)
    begin
      statusReg <= '0;
    end
    else
    begin
      for (int i = 0; i < NumDomains; i++)
      begin
        // Set and clear pulses are exclusive per domain
        if (setStatus[i])
        begin
          statusReg[i] <= 1'b1;
        end
        else if (clrStatus[i])
        begin
          statusReg[i] <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------

  // Follows addr in the same cycle
  always_comb
  begin
    case (addr)
      AddrL1Req:
        rdData = regDataT'(reqReg);
      AddrStatus:
        rdData = regDataT'(statusReg);
      // Unmapped space reads as zero
      default:
        rdData = '0;
    endcase
  end

endmodule

/* source/powerCtrl.sv */
// Power shutoff controller top with register block and one sequencer per domain
`timescale 1ns/1ps

module powerCtrl (
  input  logic                     pclk10,
  input  logic                     nprst10,
  input  logic                     wrEn,
  input  powerCtrlPkg::regAddrT    addr,
  input  powerCtrlPkg::regDataT    wrData,
  output powerCtrlPkg::regDataT    rdData,
  output powerCtrlPkg::domainMaskT gateClk,
  output powerCtrlPkg::domainMaskT isolate,
  output powerCtrlPkg::domainMaskT saveEdge,
  output powerCtrlPkg::domainMaskT restoreEdge,
  output powerCtrlPkg::domainMaskT pwr1On,
  output powerCtrlPkg::domainMaskT pwr2On,
  output powerCtrlPkg::domainMaskT rstnNonSrpg
);

  import powerCtrlPkg::*;

  // Request levels to the sequencers
  domainMaskT l1Req;

  // Status pulses back from the sequencers
  domainMaskT setStatus;
  domainMaskT clrStatus;

  // ----------------------------------------
  // Register block
  // ----------------------------------------

  pwrCtrlRegs uRegs (
    .pclk10    (pclk10),
    .nprst10   (nprst10),
    .wrEn      (wrEn),
    .addr      (addr),
    .wrData    (wrData),
    .rdData    (rdData),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .l1Req     (l1Req)
  );

  // ----------------------------------------
  // Per-domain sequencers
  // ----------------------------------------

  for (genvar i = 0; i < NumDomains; i++)
  begin : genDomain
    pwrSeqFsm uSeq (
      .pclk10      (pclk10),
      .nprst10     (nprst10),
      .l1Req       (l1Req[i]),
      .setStatus   (setStatus[i]),
      .clrStatus   (clrStatus[i]),
      .gateClk     (gateClk[i]),
      .isolate     (isolate[i]),
      .saveEdge    (saveEdge[i]),
      .restoreEdge (restoreEdge[i]),
      .pwr1On      (pwr1On[i]),
      .pwr2On      (pwr2On[i]),
      .rstnNonSrpg (rstnNonSrpg[i])
    );
  end

endmodule

/* testbench/powerCtrl_assert.sv */
// Sequencer checks bound onto each power domain state machine
`timescale 1ns/1ps

module powerCtrl_assert (
  input logic pclk10,
  input logic nprst10,
  input logic setStatus,
  input logic clrStatus,
  input logic gateClk,
  input logic isolate,
  input logic pwr1On,
  input logic pwr2On
);

  // Status pulses are exclusive
  statusExclusive: assert property (@(posedge pclk10) disable iff (!nprst10)
    !(setStatus && clrStatus))
    else $error("setStatus and clrStatus high in the same cycle");

  // Isolation follows the clock gate by two cycles
  isoAfterGate: assert property (@(posedge pclk10) disable iff (!nprst10)
    $rose(gateClk) |-> ##2 $rose(isolate))
    else $error("isolate did not rise two cycles after gateClk");

  // Both switches drop at the same edge
  switchesFallTogether: assert property (@(posedge pclk10) disable iff (!nprst10)
    $fell(pwr1On) == $fell(pwr2On))
    else $error("pwr1On and pwr2On did not fall together");

  // Switch 2 one cycle behind switch 1 on wake
  switch2AfterSwitch1: assert property (@(posedge pclk10) disable iff (!nprst10)
    $rose(pwr1On) |=> pwr2On)
    else $error("pwr2On not high one cycle after pwr1On rose");

endmodule

/* testbench/powerCtrlTb.sv */
// Testbench for the power shutoff controller, table driven with sequencer checks
`timescale 1ns/1ps

module powerCtrlTb;

  import powerCtrlPkg::*;

  // DUT signals
  logic       pclk10;
  logic       nprst10;
  logic       wrEn;
  regAddrT    addr;
  regDataT    wrData;
  regDataT    rdData;
  domainMaskT gateClk;
  domainMaskT isolate;
  domainMaskT saveEdge;
  domainMaskT restoreEdge;
  domainMaskT pwr1On;
  domainMaskT pwr2On;
  domainMaskT rstnNonSrpg;

  // One stimulus step with the values expected after its wait
  typedef struct packed {
    logic       wrEn;
    regAddrT    addr;
    regDataT    data;
    logic [7:0] waitCycles;
    regDataT    rd;
    domainMaskT gateClk;
    domainMaskT isolate;
    domainMaskT saveEdge;
    domainMaskT restoreEdge;
    domainMaskT pwr1On;
    domainMaskT pwr2On;
    domainMaskT rstn;
  } rowT;

  localparam int NumRows = 27;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  // wrEn, addr, data, wait, rdData, gateClk, isolate, save, restore, pwr1, pwr2, rstn
  // Masks are bit 1 for domain 1, bit 0 for domain 0
  rowT stimTable [NumRows] = '{
    // Reset values on both registers
    '{1'b0, AddrL1Req, 8'h00, 8'd1, 8'h00, 2'h0, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h00, 2'h0, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    // Domain 0 shutoff, checked at E+1, E+3, E+4, E+6
    '{1'b1, AddrL1Req, 8'h01, 8'd2, 8'h01, 2'h1, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd2, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h01, 2'h1, 2'h1, 2'h1, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd2, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h2, 2'h2, 2'h2},
    // Domain 0 wake, F+1, F+2, F+29, F+30, F+32, F+33, F+35, F+36
    '{1'b1, AddrL1Req, 8'h00, 8'd2, 8'h00, 2'h1, 2'h1, 2'h0, 2'h0, 2'h3, 2'h2, 2'h2},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h3, 2'h3, 2'h2},
    '{1'b0, AddrStatus, 8'h00, 8'd27, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h3, 2'h3, 2'h2},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h01, 2'h1, 2'h1, 2'h0, 2'h1, 2'h3, 2'h3, 2'h2},
    '{1'b0, AddrStatus, 8'h00, 8'd2, 8'h01, 2'h1, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h2},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h01, 2'h0, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h2},
    '{1'b0, AddrStatus, 8'h00, 8'd2, 8'h01, 2'h0, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h00, 2'h0, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    // Both down, domain 1 request dropped at E+2, wakes straight from PwrOff
    '{1'b1, AddrL1Req, 8'h03, 8'd2, 8'h03, 2'h3, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b1, AddrL1Req, 8'h01, 8'd2, 8'h01, 2'h3, 2'h3, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h03, 2'h3, 2'h3, 2'h3, 2'h0, 2'h3, 2'h3, 2'h3},
    '{1'b0, AddrStatus, 8'h00, 8'd2, 8'h03, 2'h3, 2'h3, 2'h0, 2'h0, 2'h0, 2'h0, 2'h0},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h03, 2'h3, 2'h3, 2'h0, 2'h0, 2'h2, 2'h0, 2'h0},
    '{1'b0, AddrStatus, 8'h00, 8'd1, 8'h03, 2'h3, 2'h3, 2'h0, 2'h0, 2'h2, 2'h2, 2'h0},
    '{1'b0, AddrStatus, 8'h00, 8'd28, 8'h03, 2'h3, 2'h3, 2'h0, 2'h2, 2'h2, 2'h2, 2'h0},
    '{1'b0, AddrStatus, 8'h00, 8'd6, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h2, 2'h2, 2'h2},
    // Writes to status and unused space change nothing
    '{1'b1, AddrStatus, 8'hff, 8'd2, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h2, 2'h2, 2'h2},
    '{1'b1, 4'h7, 8'hff, 8'd2, 8'h00, 2'h1, 2'h1, 2'h0, 2'h0, 2'h2, 2'h2, 2'h2},
    '{1'b0, AddrL1Req, 8'h00, 8'd1, 8'h01, 2'h1, 2'h1, 2'h0, 2'h0, 2'h2, 2'h2, 2'h2},
    // Domain 0 wakes again back to idle
    '{1'b1, AddrL1Req, 8'h00, 8'd2, 8'h00, 2'h1, 2'h1, 2'h0, 2'h0, 2'h3, 2'h2, 2'h2},
    '{1'b0, AddrL1Req, 8'h00, 8'd35, 8'h00, 2'h0, 2'h0, 2'h0, 2'h0, 2'h3, 2'h3, 2'h3}
  };

  logic [31:0] lfsrState;
  int          cycleLimit = 0;
  int          cycleCnt = 0;

  powerCtrl UUT (.*);

  // Ordering checks on every sequencer
  bind pwrSeqFsm powerCtrl_assert uSeqAssert (.*);

  initial
  begin
    pclk10 = 1'b0;
    forever
      #50 pclk10 = ~pclk10;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkData(input string what, input regDataT got, input regDataT exp);
    if (got !== exp)
      stopOnError($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkMask(input string what, input domainMaskT got, input domainMaskT exp);
    if (got !== exp)
      stopOnError($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // Watchdog sized from the table
  always @(posedge pclk10)
  begin
    cycleCnt++;
    if (cycleCnt > cycleLimit)
      stopOnError($sformatf("Timeout after %0d cycles, the run did not finish", cycleCnt));
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial
  begin
    int total;
    total = 0;
    nprst10 = 1'b0;
    wrEn = 1'b0;
    addr = '0;
    wrData = '0;
    lfsrState = 32'h6f29;
    foreach (stimTable[i])
      total += stimTable[i].waitCycles;
    cycleLimit = total + 50;

    repeat (8) @(posedge pclk10);
    #10;
    checkMask("rstnNonSrpg in reset", rstnNonSrpg, 2'h0);
    nprst10 = 1'b1;

    foreach (stimTable[i])
    begin
      wrEn = stimTable[i].wrEn;
      addr = stimTable[i].addr;
      wrData = stimTable[i].data;
      // Request writes carry random bits above the domain count
      if (wrEn && addr == AddrL1Req)
        for (int b = NumDomains; b < 8; b++)
        begin
          wrData[b] = lfsrState[0];
          lfsrState = lfsrStep(lfsrState);
        end
      repeat (stimTable[i].waitCycles)
      begin
        @(posedge pclk10);
        #10;
        wrEn = 1'b0;
      end
      checkData($sformatf("row %0d rdData", i), rdData, stimTable[i].rd);
      checkMask($sformatf("row %0d gateClk", i), gateClk, stimTable[i].gateClk);
      checkMask($sformatf("row %0d isolate", i), isolate, stimTable[i].isolate);
      checkMask($sformatf("row %0d saveEdge", i), saveEdge, stimTable[i].saveEdge);
      checkMask($sformatf("row %0d restoreEdge", i), restoreEdge, stimTable[i].restoreEdge);
      checkMask($sformatf("row %0d pwr1On", i), pwr1On, stimTable[i].pwr1On);
      checkMask($sformatf("row %0d pwr2On", i), pwr2On, stimTable[i].pwr2On);
      checkMask($sformatf("row %0d rstnNonSrpg", i), rstnNonSrpg, stimTable[i].rstn);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* powerCtrl.f */
source/powerCtrlPkg.sv
source/pwrSeqFsm.sv
source/pwrCtrlRegs.sv
source/powerCtrl.sv
testbench/powerCtrl_assert.sv
testbench/powerCtrlTb.sv

/* Bender.yml */
package:
  name: powerCtrl

sources:
  # Shared package first, then the RTL from the leaves up
  - source/powerCtrlPkg.sv
  - source/pwrSeqFsm.sv
  - source/pwrCtrlRegs.sv
  - source/powerCtrl.sv
  # Simulation only
  - target: test
    files:
      - testbench/powerCtrl_assert.sv
      - testbench/powerCtrlTb.sv
